/* source/rv_pkg.sv */
package rv_pkg;

    typedef logic [63:0] xlen_t;     // data and address word
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_idx_t;
    typedef logic [1:0]  credit_t;   // output port credits

    // address map, data side is reachable from x0 with a 12 bit offset
    localparam xlen_t RAM_BASE    = 64'h0000_0000_0000_0000; // reset pc and rom base
    localparam xlen_t KEY_BASE    = 64'h0000_0000_0000_0400; // key input register
    localparam xlen_t ART_BASE    = 64'h0000_0000_0000_0408; // character output port
    localparam xlen_t TRAP_VECTOR = 64'h0000_0000_0000_0080; // handler at rom word 32
    localparam int    ROM_WORDS   = 64;

    localparam credit_t ART_CREDITS = 2'd2;  // sink buffer depth

    // opcodes and function codes
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_OPIMM = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_DWORD = 3'b011;   // ld / sd

    localparam instr_t MRET_WORD = 32'h3020_0073;
    localparam instr_t NOP_WORD  = 32'h0000_0013; // addi x0, x0, 0

    // machine csrs
    localparam csr_idx_t CSR_MSTATUS = 12'h300;
    localparam csr_idx_t CSR_MEPC    = 12'h341;
    localparam csr_idx_t CSR_MCAUSE  = 12'h342;
    localparam int       MSTATUS_MIE  = 3;
    localparam int       MSTATUS_MPIE = 7;

    // msb marks an interrupt, code 11 is machine external
    localparam xlen_t      CAUSE_MEXT   = 64'h8000_0000_0000_000B;
    localparam logic [3:0] IRQ_EXTERNAL = 4'd1;

endpackage

/* source/rv_csr.sv */
`timescale 1ns/1ps

module rv_csr import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  trap_take,   // interrupt taken this cycle
    input  xlen_t trap_pc,     // address of the instruction that was preempted
    input  logic  mret_take,   // mret executes this cycle
    output logic  mie_bit,
    output xlen_t mepc
);

    xlen_t mstatus_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mstatus_rd;

    // read port by csr index, only the three implemented ones answer
    function automatic xlen_t csr_read(input csr_idx_t idx);
        xlen_t value;
        value = '0;
        case (idx)
            CSR_MSTATUS: value = mstatus_q;
            CSR_MEPC:    value = mepc_q;
            CSR_MCAUSE:  value = mcause_q;
            default:     value = '0;
        endcase
        return value;
    endfunction

    always_comb begin
        mstatus_rd = csr_read(CSR_MSTATUS);
        mepc       = csr_read(CSR_MEPC);
    end

    assign mie_bit = mstatus_rd[MSTATUS_MIE];

    // mstatus, interrupts enabled out of reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_q              <= '0;
            mstatus_q[MSTATUS_MIE] <= 1'b1;
        end else if (trap_take) begin
            mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];  // remember old enable
            mstatus_q[MSTATUS_MIE]  <= 1'b0;                    // mask while in handler
        end else if (mret_take) begin
            mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
            mstatus_q[MSTATUS_MPIE] <= 1'b1;
        end
    end

    // trap record
    always_ff @(posedge clk) begin
        if (trap_take) begin
            mepc_q   <= trap_pc;     // mret resumes here
            mcause_q <= CAUSE_MEXT;  // only external interrupts exist
        end
    end

    // core arbitrates trap against execution, both at once would corrupt mstatus
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (!reset)
        !(trap_take && mret_take));

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  instr_t     instruction,       // rom word at pc, same cycle
    output xlen_t      pc,
    output logic       heartbeat,
    input  logic [3:0] interrupt_vector,
    output logic       interrupt_ack,
    output xlen_t      bus_address,
    output xlen_t      bus_write_data,
    output logic       bus_write_enable,
    output logic       bus_read_enable,
    input  xlen_t      bus_read_data,     // valid one cycle after the read enable
    input  logic       write_stall        // output port out of credits
);

    instr_t     ir;
    xlen_t      regs [32];
    logic       bubble;     // ir holds a wrong-path fetch
    logic       lb_step;    // second pass of ld, data is on the bus

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    xlen_t      ir_pc;      // address of the word in ir

    logic       is_lui;
    logic       is_addi;
    logic       is_ld;
    logic       is_sd;
    logic       is_jal;
    logic       is_mret;

    logic       run;        // ir executes normally this cycle
    logic       trap_take;
    logic       mret_take;
    logic       load_req;
    logic       load_done;
    logic       store_block;
    logic       store_go;
    logic       store_retry;
    logic       rf_we;
    xlen_t      rf_wdata;
    logic       mie_bit;
    xlen_t      mepc;

    // decode
    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign rd     = ir[11:7];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign imm_i  = {{52{ir[31]}}, ir[31:20]};
    assign imm_s  = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u  = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_j  = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];  // x0 reads zero
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
    assign ir_pc   = pc - 64'd4;                     // pc already moved past ir

    assign is_lui  = (opcode == OP_LUI);
    assign is_addi = (opcode == OP_OPIMM) && (funct3 == F3_ADDI);
    assign is_ld   = (opcode == OP_LOAD) && (funct3 == F3_DWORD);
    assign is_sd   = (opcode == OP_STORE) && (funct3 == F3_DWORD);
    assign is_jal  = (opcode == OP_JAL);
    assign is_mret = (ir == MRET_WORD);

    // interrupt waits out a bubble and the second half of a load
    assign trap_take = !bubble && !lb_step && mie_bit && (interrupt_vector == IRQ_EXTERNAL);
    assign run       = !bubble && !trap_take;
    assign mret_take = run && is_mret;

    assign load_req  = run && is_ld && !lb_step;
    assign load_done = run && is_ld && lb_step;

    // a store still in flight is not yet counted by the bus, so hold off too
    assign store_block = write_stall || bus_write_enable;
    assign store_go    = run && is_sd && !store_block;
    assign store_retry = run && is_sd && store_block;

    // register file write port
    assign rf_we = (run && (is_lui || is_addi || is_jal)) || load_done;

    always_comb begin
        rf_wdata = imm_u;                    // lui
        if (is_addi)
            rf_wdata = rs1_val + imm_i;
        else if (is_jal)
            rf_wdata = pc;                   // link is ir_pc + 4
        else if (is_ld)
            rf_wdata = bus_read_data;
    end

    always_ff @(posedge clk) begin
        if (rf_we && (rd != '0))
            regs[rd] <= rf_wdata;
    end

    // fetch register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= NOP_WORD;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;
        end
    end

    // pc, bubble and step control
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc               <= RAM_BASE;
            bubble           <= 1'b0;
            lb_step          <= 1'b0;
            interrupt_ack    <= 1'b0;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
        end else begin
            pc               <= pc + 64'd4;  // default sequential fetch
            bubble           <= 1'b0;
            interrupt_ack    <= trap_take;   // cycle after the request was seen
            bus_read_enable  <= load_req;
            bus_write_enable <= store_go;
            if (trap_take) begin
                pc     <= TRAP_VECTOR;
                bubble <= 1'b1;
            end else if (run && is_jal) begin
                pc     <= ir_pc + imm_j;
                bubble <= 1'b1;
            end else if (mret_take) begin
                pc     <= mepc;
                bubble <= 1'b1;
            end else if (load_req || store_retry) begin
                pc     <= ir_pc;             // refetch the same ld / sd
                bubble <= 1'b1;
            end
            if (load_req)
                lb_step <= 1'b1;
            else if (load_done)
                lb_step <= 1'b0;
        end
    end

    // bus payload
    always_ff @(posedge clk) begin
        if (load_req)
            bus_address <= rs1_val + imm_i;
        else if (store_go)
            bus_address <= rs1_val + imm_s;
        if (store_go)
            bus_write_data <= rs2_val;
    end

    rv_csr u_csr (
        .clk       (clk),
        .reset     (reset),
        .trap_take (trap_take),
        .trap_pc   (ir_pc),
        .mret_take (mret_take),
        .mie_bit   (mie_bit),
        .mepc      (mepc)
    );

    a_bus_rw_excl: assert property (@(posedge clk) disable iff (!reset)
        !(bus_read_enable && bus_write_enable));

    // mie stays clear until mret, which needs at least a bubble in between
    a_ack_single: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> !interrupt_ack);

endmodule

/* source/rv_imem.sv */
`timescale 1ns/1ps

module rv_imem import rv_pkg::*; (
    input  xlen_t  pc,
    output instr_t instruction
);

    instr_t                         rom [ROM_WORDS];
    xlen_t                          offset;     // byte offset into the rom
    logic [$clog2(ROM_WORDS)-1:0]   word_idx;
    logic                           in_range;

    initial begin
        $readmemh("tb/program.hex", rom);
    end

    assign offset   = pc - RAM_BASE;
    assign word_idx = offset[$clog2(ROM_WORDS)+1:2];
    assign in_range = (offset < xlen_t'(ROM_WORDS * 4));

    // outside the rom the core just sees nops
    assign instruction = in_range ? rom[word_idx] : NOP_WORD;

endmodule

/* source/rv_bus.sv */
`timescale 1ns/1ps

module rv_bus import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  xlen_t bus_address,
    input  xlen_t bus_write_data,
    input  logic  bus_write_enable,
    input  logic  bus_read_enable,
    output xlen_t bus_read_data,
    output logic  write_stall,
    input  xlen_t key_data,
    output logic  art_valid,
    output xlen_t art_data,
    input  logic  art_credit_return   // one per character the sink consumed
);

    credit_t credits;
    logic    art_hit;    // store to the output port this cycle

    assign art_hit     = bus_write_enable && (bus_address == ART_BASE);
    assign write_stall = (credits == '0);

    // read data and output payload
    always_ff @(posedge clk) begin
        if (bus_read_enable)
            bus_read_data <= (bus_address == KEY_BASE) ? key_data : '0;  // no ram behind
        if (art_hit)
            art_data <= bus_write_data;
    end

    // credit counter, saturates at both ends
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            credits   <= ART_CREDITS;
            art_valid <= 1'b0;
        end else begin
            art_valid <= art_hit;
            case ({art_hit, art_credit_return})
                2'b10: begin
                    if (credits != '0)
                        credits <= credits - 1'b1;
                end
                2'b01: begin
                    if (credits != ART_CREDITS)
                        credits <= credits + 1'b1;
                end
                default: credits <= credits;   // spend and return cancel
            endcase
        end
    end

    // core must hold a store back while the sink is full
    a_art_credit: assert property (@(posedge clk) disable iff (!reset)
        art_valid |-> ($past(credits) != '0));

endmodule

/* source/rv_top.sv */
`timescale 1ns/1ps

module rv_top import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  xlen_t      key_data,
    input  logic [3:0] interrupt_vector,
    output logic       interrupt_ack,
    output logic       art_valid,
    output xlen_t      art_data,
    input  logic       art_credit_return,
    output xlen_t      pc,
    output logic       heartbeat
);

    instr_t instruction;
    xlen_t  bus_address;
    xlen_t  bus_write_data;
    xlen_t  bus_read_data;
    logic   bus_write_enable;
    logic   bus_read_enable;
    logic   write_stall;

    rv_core u_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .write_stall      (write_stall)
    );

    rv_imem u_imem (
        .pc          (pc),
        .instruction (instruction)
    );

    rv_bus u_bus (
        .clk               (clk),
        .reset             (reset),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_data     (bus_read_data),
        .write_stall       (write_stall),
        .key_data          (key_data),
        .art_valid         (art_valid),
        .art_data          (art_data),
        .art_credit_return (art_credit_return)
    );

endmodule

/* tb/tb_rv_top.sv */
`timescale 1ns/1ps

module tb_rv_top import rv_pkg::*; ();

    localparam xlen_t MARKER = 64'h0000_0000_5A5A_5000;  // lui x6 value in the handler

    logic       clk;
    logic       reset;
    xlen_t      key_data;
    logic [3:0] interrupt_vector;
    logic       interrupt_ack;
    logic       art_valid;
    xlen_t      art_data;
    logic       art_credit_return;
    xlen_t      pc;
    logic       heartbeat;

    integer seed = 18;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int owed = 0;           // credits the sink still has to return
    int sink_delay = 0;
    logic withhold = 1'b0;
    int hold_pulses = 0;    // output pulses seen while credits are held back
    int expected_hold = 0;
    int data_pulses = 0;
    int marker_seen = 0;
    int ack_count = 0;
    logic key_pending = 1'b0;

    rv_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog for the whole run
    initial begin
        #2_000_000;
        $display("run limit reached before the test sequence ended");
        $display("Some tests failed");
        $finish;
    end

    // observe outputs mid cycle where they are stable
    always @(negedge clk) begin
        if (art_valid) begin
            owed++;
            if (withhold)
                hold_pulses++;
            if (art_data == MARKER)
                marker_seen++;
            else begin
                data_pulses++;
                key_pending = 1'b1;  // next loop pass reads a new key
            end
        end
        if (interrupt_ack)
            ack_count++;
    end

    // credit sink and key source driven 1 ns after the edge
    always @(posedge clk) begin
        #1;
        art_credit_return <= 1'b0;
        if (key_pending) begin
            key_data    <= {$random(seed), $random(seed)};
            key_pending = 1'b0;
        end
        if (!withhold && owed > 0) begin
            if (sink_delay == 0) begin
                art_credit_return <= 1'b1;
                owed--;
                sink_delay = $random(seed) & 3;  // random return latency
            end else
                sink_delay--;
        end
    end

    // reset state while held and on the first edge after release
    a_reset_state: assert property (@(posedge clk) (!reset || $rose(reset)) |->
        (pc == RAM_BASE && !art_valid && !interrupt_ack))
        else begin
            $display("FAILED %0t reset pc/art_valid/interrupt_ack expected %h/0/0 got %h/%b/%b",
                     $time, RAM_BASE, $sampled(pc), $sampled(art_valid),
                     $sampled(interrupt_ack));
            errors++;
        end

    // loop output is the key of that pass plus one
    a_data_path: assert property (@(posedge clk) disable iff (!reset)
        (art_valid && art_data != MARKER) |-> (art_data == key_data + 64'd1))
        else begin
            $display("FAILED %0t art_data expected %h got %h",
                     $time, $sampled(key_data) + 64'd1, $sampled(art_data));
            errors++;
        end

    a_heartbeat: assert property (@(posedge clk) (reset && $past(reset)) |->
        (heartbeat != $past(heartbeat)))
        else begin
            $display("heartbeat did not toggle at %0t", $time);
            errors++;
        end

    a_credit_limit: assert property (@(posedge clk) hold_pulses <= ART_CREDITS)
        else begin
            $display("output kept going without credits at %0t", $time);
            errors++;
        end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp)
        else begin
            $display("FAILED %0t %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic wait_data_pulses(input int n, input int limit);
        int target;
        target = data_pulses + n;
        for (int i = 0; i < limit; i++) begin
            @(negedge clk);
            #1;  // counts from the negedge monitor are settled
            if (data_pulses >= target)
                return;
        end
        $display("timeout waiting for %0d output values at %0t", n, $time);
        errors++;
    endtask

    task automatic wait_ack_count(input int n, input int limit);
        for (int i = 0; i < limit; i++) begin
            @(negedge clk);
            #1;
            if (ack_count >= n)
                return;
        end
        $display("timeout waiting for interrupt_ack at %0t", $time);
        errors++;
    endtask

    task automatic wait_pc_at(input xlen_t target, input int limit);
        for (int i = 0; i < limit; i++) begin
            @(negedge clk);
            #1;
            if (pc == target)
                return;
        end
        $display("timeout waiting for pc %h at %0t", target, $time);
        errors++;
    endtask

    task automatic wait_in_loop(input int limit);
        for (int i = 0; i < limit; i++) begin
            @(negedge clk);
            #1;
            if (pc < RAM_BASE + 64'h10)
                return;
        end
        $display("pc did not return into the main loop by %0t", $time);
        errors++;
    endtask

    task automatic wait_marker(input int n, input int limit);
        for (int i = 0; i < limit; i++) begin
            @(negedge clk);
            #1;
            if (marker_seen >= n)
                return;
        end
        $display("handler marker not seen on art_data by %0t", $time);
        errors++;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    // one interrupt round trip through the handler
    task automatic run_interrupt(input int ack_target);
        @(posedge clk);
        #1 interrupt_vector = IRQ_EXTERNAL;
        wait_ack_count(ack_target, 40);
        wait_pc_at(TRAP_VECTOR + 64'd4, 20);  // held until the lui runs
        @(posedge clk);
        #1 interrupt_vector = 4'd0;
        wait_marker(ack_target, 40);
        check_value("interrupt_ack count", ack_count, ack_target);
    endtask

    initial begin
        int mark;
        reset             = 1'b0;
        key_data          = {$random(seed), $random(seed)};
        interrupt_vector  = 4'd0;
        art_credit_return = 1'b0;

        mark = errors;
        repeat (3) @(posedge clk);
        #1 reset = 1'b1;
        idle_cycles(2);
        report_test("reset", mark);

        mark = errors;
        wait_data_pulses(4, 200);
        report_test("data path", mark);

        mark = errors;
        @(posedge clk);
        #25;
        withhold      = 1'b1;
        hold_pulses   = 0;
        expected_hold = ART_CREDITS - owed;   // credits still inside the dut
        idle_cycles(30);
        check_value("pulses without credit", hold_pulses, expected_hold);
        @(posedge clk);
        #25 withhold = 1'b0;
        hold_pulses = 0;
        wait_data_pulses(4, 200);
        report_test("credit flow", mark);

        mark = errors;
        run_interrupt(1);
        report_test("interrupt entry", mark);

        mark = errors;
        wait_in_loop(40);
        wait_data_pulses(3, 200);
        run_interrupt(2);
        wait_in_loop(40);
        wait_data_pulses(2, 200);
        report_test("mret return", mark);

        mark = errors;
        idle_cycles(4);
        report_test("heartbeat", mark);

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* src.f */
source/rv_pkg.sv
source/rv_csr.sv
source/rv_core.sv
source/rv_imem.sv
source/rv_bus.sv
source/rv_top.sv
tb/tb_rv_top.sv

/* run.sh */
#!/bin/bash
# build and run the testbench with Verilator, verdict comes from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_rv_top -f src.f -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* tb/program.hex */
// one 32 bit instruction word per line, @ gives the rom word index
// main loop at word 0: ld x5 key, addi x5 +1, sd x5 out, jal back
40003283
00128293
40503423
ff5ff06f
00000013
00000013
00000013
00000013
// handler at word 32 (byte 0x80): lui x6 marker, sd x6 out, mret
@20
5a5a5337
40603423
30200073
00000013
00000013
00000013
00000013
